// File: mmu304.f
verilog/mmu_pkg.sv
verilog/mmu_page_slot.sv
verilog/mmu_apb_regs.sv
verilog/mmu_translate.sv
verilog/mmu304.sv
testbench/mmu_asserts.sv
testbench/mmu_checker.sv
testbench/mmu_tb.sv

// File: testbench/mmu_vectors.txt
// op addr data ctl exp flags, all hex; op 1 apb write, 2 apb read, 3 translate, 0 end
// write: ctl = pstrb, flags = pslverr; read: exp = prdata; translate: ctl = user,write, flags = nr,le,ro
2 1f7a 0000 0 000000 0  // SR0 after reset
2 154e 0000 0 000000 0  // SR3 after reset
3 1234 0000 0 001234 0  // mmu off
3 e010 0000 0 3fe010 0  // mmu off, page 7 to top
2 14d0 0000 0 000000 1  // unlisted offset
1 0000 ffff 3 000000 1
1 14e0 1234 3 000000 0  // KPAR0
2 14e0 0000 0 001234 0
1 14e0 5600 2 000000 0  // high byte only
2 14e0 0000 0 005634 0
1 14e0 0078 1 000000 0  // low byte only
2 14e0 0000 0 005678 0
1 14c0 ffff 3 000000 0  // KPDR0 all ones
2 14c0 0000 0 007f0e 0
1 14c0 7f06 3 000000 0
1 14e2 0100 3 000000 0  // page 1 non-resident
1 14c2 7f00 3 000000 0
1 14e4 0200 3 000000 0  // page 2 read-only, plf 10
1 14c4 1002 3 000000 0
1 14e6 0300 3 000000 0  // page 3 downward, plf 70
1 14c6 700e 3 000000 0
1 1fa0 8000 3 000000 0  // UPAR0
1 1f80 7f06 3 000000 0
2 1f80 0000 0 007f06 0
1 154e 0030 3 000000 0
2 154e 0000 0 000030 0
1 154e 0000 3 000000 0
1 1f7a 0001 3 000000 0  // enable mapping
2 1f7a 0000 0 000001 0
3 0104 0000 0 019f04 0  // 18-bit mode
3 0200 0000 0 01a000 0
3 0200 0000 2 000200 0  // user slot
2 1f7a 0000 0 000061 0
1 154e 0010 3 000000 0  // 22-bit mode
3 0200 0000 2 200200 0
3 0104 0000 0 159f04 0
3 2010 0000 0 004010 4  // non-resident
2 1f7a 0000 0 008003 0
3 0104 0000 0 159f04 0  // SR0 frozen
3 4000 0000 1 008000 1
2 1f7a 0000 0 008003 0
1 1f7a 0001 3 000000 0  // clear aborts
2 1f7a 0000 0 000003 0
3 4000 0000 1 008000 1  // read-only
2 1f7a 0000 0 002005 0
1 1f7a 0001 3 000000 0
3 4400 0000 0 008400 0  // limit edge
3 4440 0000 0 008440 2  // above limit
2 1f7a 0000 0 004005 0
1 1f7a 0001 3 000000 0
3 7c00 0000 0 00dc00 0  // downward edge
3 7bc0 0000 0 00dbc0 2  // below limit
2 1f7a 0000 0 004007 0
1 1f7a 0001 3 000000 0
3 0104 0000 1 159f04 0  // write sets W
2 14c0 0000 0 007f46 0
1 14c0 7f06 3 000000 0
2 14c0 0000 0 007f06 0
3 0000 0000 0 159e00 0  // back-to-back burst
3 0040 0000 2 200040 0
3 1fff 0000 0 15bdff 0
3 1000 0000 3 201000 0
3 7c40 0000 0 00dc40 0
3 4010 0000 0 008010 0
2 1f80 0000 0 007f46 0
2 1f7a 0000 0 000005 0
0 0000 0000 0 000000 0

// File: testbench/mmu_tb.sv
/* MMU testbench top */
`timescale 1ns/10ps

module mmu_tb;
   import mmu_pkg::*;

   localparam int MAX_OPS = 128;
   localparam int NUM_COL = 6;                 // fields per vector line
   localparam int TIMEOUT = 200;               // cycles per wait

   logic            clk = 1'b0;
   logic            sr_rst;
   logic            psel, penable, pwrite;
   logic [12:0]     paddr;
   logic [15:0]     pwdata;
   logic [1:0]      pstrb;
   logic [15:0]     prdata;
   logic            pready, pslverr;
   logic            req_valid, req_ready;
   xlat_req_t       req;
   logic            rsp_valid, rsp_ready;
   xlat_rsp_t       rsp;
   logic            umap_en;

   // expected values travel with the stimulus
   logic            apb_chk_data;
   logic [15:0]     exp_rdata;
   logic            exp_err;
   logic [PA_W-1:0] exp_pa;
   logic [2:0]      exp_abt;

   logic [31:0]     vec_mem [0:MAX_OPS*NUM_COL-1];
   logic [31:0]     lcg_state = 32'h90af;
   int              n_issued  = 0;
   int              n_done    = 0;
   int              n_ops     = 0;
   int              n_pass, n_fail, n_pending;
   bit              timed_out = 1'b0;

   always #2 clk = ~clk;                       // 4 ns period

   mmu304 #(.NUM_PAGES(NUM_PAGES)) i_mmu304
   (
      .clk       (clk),
      .sr_rst    (sr_rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .rsp_ready (rsp_ready),
      .umap_en   (umap_en)
   );

   mmu_checker i_checker
   (
      .clk          (clk),
      .sr_rst       (sr_rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .pready       (pready),
      .prdata       (prdata),
      .pslverr      (pslverr),
      .umap_en      (umap_en),
      .apb_chk_data (apb_chk_data),
      .exp_rdata    (exp_rdata),
      .exp_err      (exp_err),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req          (req),
      .exp_pa       (exp_pa),
      .exp_abt      (exp_abt),
      .rsp_valid    (rsp_valid),
      .rsp_ready    (rsp_ready),
      .rsp          (rsp),
      .n_pass       (n_pass),
      .n_fail       (n_fail),
      .n_pending    (n_pending)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(negedge clk)
   begin
      lcg_state = lcg_next(lcg_state);
      rsp_ready = lcg_state[15];               // random back-pressure
   end

   always @(posedge clk)
   begin
      if (!sr_rst && rsp_valid && rsp_ready)
         n_done <= n_done + 1;
   end

   // all outstanding translations must be back before register access
   task automatic wait_drain();
      int cnt;
      cnt = 0;
      while (n_done != n_issued && cnt < TIMEOUT)
      begin
         @(posedge clk);
         cnt++;
      end
      if (n_done != n_issued)
      begin
         timed_out = 1'b1;
         $display("timeout: %0d translation responses never arrived", n_issued - n_done);
      end
      if (cnt > 0)
         @(negedge clk);
   endtask

   task automatic apb_access(input logic wr, input logic [12:0] addr, input logic [15:0] data,
                             input logic [1:0] strb, input logic [15:0] rdata, input logic err);
      int cnt;
      psel         = 1'b1;                     // setup phase
      penable      = 1'b0;
      pwrite       = wr;
      paddr        = addr;
      pwdata       = wr ? data : 16'h0000;
      pstrb        = wr ? strb : 2'b00;
      apb_chk_data = ~wr;
      exp_rdata    = rdata;
      exp_err      = err;
      @(negedge clk);
      penable = 1'b1;                          // access phase
      cnt     = 0;
      @(posedge clk);
      while (!pready && cnt < TIMEOUT)
      begin
         @(posedge clk);
         cnt++;
      end
      if (!pready)
      begin
         timed_out = 1'b1;
         $display("timeout: APB slave never raised pready at offset %h", addr);
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic run_translation(input logic [15:0] va, input logic [1:0] ctl,
                                  input logic [PA_W-1:0] pa, input logic [2:0] abt);
      int cnt;
      req_valid  = 1'b1;
      req.va     = va;
      req.user   = ctl[1];
      req.write  = ctl[0];
      exp_pa     = pa;
      exp_abt    = abt;
      cnt        = 0;
      @(posedge clk);
      while (!req_ready && cnt < TIMEOUT)
      begin
         @(posedge clk);
         cnt++;
      end
      if (req_ready)
         n_issued++;
      else
      begin
         timed_out = 1'b1;
         $display("timeout: translation request for va %h was never accepted", va);
      end
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   initial
   begin
      int          base;
      logic [31:0] op;
      bit          stop;
      stop         = 1'b0;
      sr_rst       = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      pstrb        = '0;
      req_valid    = 1'b0;
      req          = '0;
      rsp_ready    = 1'b0;
      apb_chk_data = 1'b0;
      exp_rdata    = '0;
      exp_err      = 1'b0;
      exp_pa       = '0;
      exp_abt      = '0;
      $readmemh("testbench/mmu_vectors.txt", vec_mem);
      repeat (10) @(posedge clk);
      @(negedge clk);
      sr_rst = 1'b0;
      for (int i = 0; i < MAX_OPS && !timed_out && !stop; i++)
      begin
         base = i * NUM_COL;
         op   = vec_mem[base];
         if (op === 32'd1 || op === 32'd2)
         begin
            wait_drain();
            if (!timed_out)
               apb_access(op === 32'd1, vec_mem[base+1][12:0], vec_mem[base+2][15:0],
                          vec_mem[base+3][1:0], vec_mem[base+4][15:0], vec_mem[base+5][0]);
            n_ops++;
         end
         else if (op === 32'd3)
         begin
            run_translation(vec_mem[base+1][15:0], vec_mem[base+3][1:0],
                            vec_mem[base+4][PA_W-1:0], vec_mem[base+5][2:0]);
            n_ops++;
         end
         else
            stop = 1'b1;                       // end marker
      end
      if (!timed_out)
         wait_drain();
      $display("checks passed %0d, failed %0d, not run %0d, assertion failures %0d",
               n_pass, n_fail, n_ops - n_pass - n_fail,
               i_mmu304.i_translate.i_asserts.fail_count);
      if (!timed_out && n_fail == 0 && n_pass == n_ops && n_pending == 0 &&
          i_mmu304.i_translate.i_asserts.fail_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: testbench/mmu_checker.sv
/* MMU response checker */
`timescale 1ns/10ps

module mmu_checker
(
   input  logic                     clk,
   input  logic                     sr_rst,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  logic [12:0]              paddr,
   input  logic [15:0]              pwdata,
   input  logic                     pready,
   input  logic [15:0]              prdata,
   input  logic                     pslverr,
   input  logic                     umap_en,
   input  logic                     apb_chk_data,
   input  logic [15:0]              exp_rdata,
   input  logic                     exp_err,
   input  logic                     req_valid,
   input  logic                     req_ready,
   input  mmu_pkg::xlat_req_t       req,
   input  logic [mmu_pkg::PA_W-1:0] exp_pa,
   input  logic [2:0]               exp_abt,
   input  logic                     rsp_valid,
   input  logic                     rsp_ready,
   input  mmu_pkg::xlat_rsp_t       rsp,
   output int                       n_pass,
   output int                       n_fail,
   output int                       n_pending
);
   import mmu_pkg::*;

   typedef struct packed {
      xlat_req_t       req;
      logic [PA_W-1:0] pa;
      logic [2:0]      abt;                    // nr, le, ro
   } exp_item_t;

   exp_item_t  exp_q [$];                      // translations in flight
   exp_item_t  head;
   logic [2:0] got_abt;

   initial
   begin
      n_pass    = 0;
      n_fail    = 0;
      n_pending = 0;
   end

   task check_apb();
      logic umap_bad;                          // umap_en against SR3 read data
      umap_bad = !pwrite && paddr[12:1] == OFS_SR3[12:1]
                 && umap_en !== exp_rdata[SR3_UMAP_BIT];
      if (pslverr === exp_err && (!apb_chk_data || prdata === exp_rdata) && !umap_bad)
      begin
         n_pass++;
         if (pwrite)
            $display("[ok]   %0.2f ns: apb write %h data %h err %b",
                     $realtime, paddr, pwdata, pslverr);
         else
            $display("[ok]   %0.2f ns: apb read %h data %h err %b",
                     $realtime, paddr, prdata, pslverr);
      end
      else
      begin
         n_fail++;
         $display("[FAIL] %0.2f ns: apb %s %h data %h err %b umap %b, expected %h %b",
                  $realtime, pwrite ? "write" : "read", paddr, prdata, pslverr,
                  umap_en, exp_rdata, exp_err);
      end
   endtask

   task check_rsp();
      if (exp_q.size() == 0)
      begin
         n_fail++;
         $display("a translation response for pa %h arrived with no request outstanding",
                  rsp.pa);
      end
      else
      begin
         head    = exp_q.pop_front();          // results return in order
         got_abt = {rsp.abort_nr, rsp.abort_le, rsp.abort_ro};
         if (rsp.pa === head.pa && got_abt === head.abt)
         begin
            n_pass++;
            $display("[ok]   %0.2f ns: translate va %h user %b write %b pa %h aborts %b",
                     $realtime, head.req.va, head.req.user, head.req.write, rsp.pa, got_abt);
         end
         else
         begin
            n_fail++;
            $display("[FAIL] %0.2f ns: translate va %h gave pa %h aborts %b, expected %h %b",
                     $realtime, head.req.va, rsp.pa, got_abt, head.pa, head.abt);
         end
      end
   endtask

   always @(posedge clk)
   begin
      if (!sr_rst)
      begin
         if (psel & penable & pready)
            check_apb();
         if (rsp_valid & rsp_ready)
            check_rsp();
         if (req_valid & req_ready)
            exp_q.push_back({req, exp_pa, exp_abt});
         n_pending = exp_q.size();
      end
   end

endmodule

// File: testbench/mmu_asserts.sv
/* MMU translate handshake assertions */
`timescale 1ns/10ps

module mmu_asserts
#(
   parameter int NUM_PAGES = mmu_pkg::NUM_PAGES
)
(
   input  logic                 clk,
   input  logic                 sr_rst,
   input  logic                 rsp_valid,
   input  logic                 rsp_ready,
   input  mmu_pkg::xlat_rsp_t   rsp,
   input  logic [NUM_PAGES-1:0] w_set
);

   int fail_count = 0;                         // read by the testbench top

   a_rsp_stable : assert property (@(posedge clk) disable iff (sr_rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
   else
   begin
      $error("response dropped or changed while stalled");
      fail_count++;
   end

   a_no_rsp_in_reset : assert property (@(posedge clk) sr_rst |=> !rsp_valid)
   else
   begin
      $error("rsp_valid high during reset");
      fail_count++;
   end

   a_w_set_onehot : assert property (@(posedge clk) disable iff (sr_rst) $onehot0(w_set))
   else
   begin
      $error("w_set has more than one bit set");
      fail_count++;
   end

endmodule

bind mmu_translate mmu_asserts #(.NUM_PAGES(NUM_PAGES)) i_asserts
(
   .clk       (clk),
   .sr_rst    (sr_rst),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp       (rsp),
   .w_set     (w_set)
);

// File: verilog/mmu304.sv
/* PDP-11 MMU top level */
`timescale 1ns/10ps

module mmu304
#(
   parameter int NUM_PAGES = mmu_pkg::NUM_PAGES
)
(
   input  logic                  clk,
   input  logic                  sr_rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [12:0]           paddr,
   input  logic [15:0]           pwdata,
   input  logic [1:0]            pstrb,
   output logic [15:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  logic                  req_valid,
   input  mmu_pkg::xlat_req_t    req,
   output logic                  req_ready,
   output logic                  rsp_valid,
   output mmu_pkg::xlat_rsp_t    rsp,
   input  logic                  rsp_ready,
   output logic                  umap_en
);
   import mmu_pkg::*;

   slot_wr_t     [NUM_PAGES-1:0] slot_wr;      // per-slot write commands
   page_desc_t   [NUM_PAGES-1:0] slot_desc;    // all descriptors
   logic         [NUM_PAGES-1:0] w_set;
   xlat_status_t                 status;
   mmu_ctrl_t                    ctrl;

   mmu_apb_regs #(.NUM_PAGES(NUM_PAGES)) i_regs
   (
      .clk       (clk),
      .sr_rst    (sr_rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .slot_wr   (slot_wr),
      .slot_desc (slot_desc),
      .status    (status),
      .ctrl      (ctrl),
      .umap_en   (umap_en)
   );

   // kernel pages 0..7, user pages 8..15
   for (genvar i = 0; i < NUM_PAGES; i++)
   begin : g_slot
      mmu_page_slot i_slot
      (
         .clk    (clk),
         .sr_rst (sr_rst),
         .wr     (slot_wr[i]),
         .w_set  (w_set[i]),
         .desc   (slot_desc[i])
      );
   end

   mmu_translate #(.NUM_PAGES(NUM_PAGES)) i_translate
   (
      .clk       (clk),
      .sr_rst    (sr_rst),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .rsp_ready (rsp_ready),
      .slot_desc (slot_desc),
      .ctrl      (ctrl),
      .w_set     (w_set),
      .status    (status)
   );

endmodule

// File: verilog/mmu_translate.sv
/* MMU address translation pipeline */
`timescale 1ns/10ps

module mmu_translate
#(
   parameter int NUM_PAGES = mmu_pkg::NUM_PAGES
)
(
   input  logic                                clk,
   input  logic                                sr_rst,
   input  logic                                req_valid,
   input  mmu_pkg::xlat_req_t                  req,
   output logic                                req_ready,
   output logic                                rsp_valid,
   output mmu_pkg::xlat_rsp_t                  rsp,
   input  logic                                rsp_ready,
   input  mmu_pkg::page_desc_t [NUM_PAGES-1:0] slot_desc,
   input  mmu_pkg::mmu_ctrl_t                  ctrl,
   output logic [NUM_PAGES-1:0]                w_set,
   output mmu_pkg::xlat_status_t               status
);
   import mmu_pkg::*;

   localparam int IDX_W = $clog2(NUM_PAGES);

   // stage 1, descriptor lookup and checks
   logic             s1_valid;
   xlat_req_t        s1_req;
   logic             s1_ready;
   logic [IDX_W-1:0] s1_idx;
   page_desc_t       s1_desc;
   logic [6:0]       s1_blk;                   // block within the page
   logic             s1_nr, s1_le, s1_ro;

   // stage 2, address add and response
   logic             s2_valid;
   logic             s2_ready;
   logic [VA_W-1:0]  s2_va;
   logic             s2_user;
   logic             s2_write;
   logic [PAR_W-1:0] s2_par;
   logic             s2_mapped;
   logic             s2_en22;
   logic             s2_nr, s2_le, s2_ro;
   logic [IDX_W-1:0] s2_idx;
   logic [PA_W-1:0]  s2_sum;
   logic             s2_abort;
   logic             xfer;                     // response handshake

   assign s2_ready  = ~s2_valid | rsp_ready;
   assign s1_ready  = ~s1_valid | s2_ready;
   assign req_ready = s1_ready;

   always_ff @(posedge clk)
   begin
      if (sr_rst)
         s1_valid <= 1'b0;
      else if (s1_ready)
         s1_valid <= req_valid;
   end

   always_ff @(posedge clk)
   begin
      if (req_valid & s1_ready)
         s1_req <= req;
   end

   assign s1_idx  = {s1_req.user, s1_req.va[15:13]};
   assign s1_desc = slot_desc[s1_idx];
   assign s1_blk  = s1_req.va[12:6];

   assign s1_nr = ctrl.mmu_en & ~s1_desc.acf[0];
   assign s1_ro = ctrl.mmu_en & s1_req.write & ~s1_desc.acf[1];
   assign s1_le = ctrl.mmu_en & (~s1_desc.ed & (s1_blk > s1_desc.plf)
                               |  s1_desc.ed & (s1_blk < s1_desc.plf));

   always_ff @(posedge clk)
   begin
      if (sr_rst)
         s2_valid <= 1'b0;
      else if (s2_ready)
         s2_valid <= s1_valid;
   end

   // mapping mode is captured so a stalled response stays put
   always_ff @(posedge clk)
   begin
      if (s1_valid & s2_ready)
      begin
         s2_va     <= s1_req.va;
         s2_user   <= s1_req.user;
         s2_write  <= s1_req.write;
         s2_par    <= s1_desc.par;
         s2_mapped <= ctrl.mmu_en;
         s2_en22   <= ctrl.en_22bit;
         s2_nr     <= s1_nr;
         s2_le     <= s1_le;
         s2_ro     <= s1_ro;
      end
   end

   assign s2_idx   = {s2_user, s2_va[15:13]};
   assign s2_sum   = {s2_par, 6'b000000} + PA_W'(s2_va[12:0]);
   assign s2_abort = s2_nr | s2_le | s2_ro;
   assign xfer     = s2_valid & rsp_ready;

   always_comb
   begin
      if (!s2_mapped)
         rsp.pa = {(&s2_va[15:13]) ? 6'o77 : 6'o00, s2_va}; // page 7 to I/O page
      else if (s2_en22)
         rsp.pa = s2_sum;
      else
         rsp.pa = {4'h0, s2_sum[17:0]};        // 18-bit mode
      rsp.abort_nr = s2_nr;
      rsp.abort_le = s2_le;
      rsp.abort_ro = s2_ro;
   end

   assign rsp_valid = s2_valid;

   assign w_set = (xfer & s2_mapped & s2_write & ~s2_abort)
                ? NUM_PAGES'(1) << s2_idx
                : '0;

   always_comb
   begin
      status       = '0;
      status.valid = xfer & s2_mapped & ~ctrl.frozen;
      status.user  = s2_user;
      status.page  = s2_va[15:13];
      status.nr    = s2_nr;
      status.le    = s2_le;
      status.ro    = s2_ro;
   end

endmodule

// File: verilog/mmu_apb_regs.sv
/* MMU APB register block */
`timescale 1ns/10ps

module mmu_apb_regs
#(
   parameter int NUM_PAGES = mmu_pkg::NUM_PAGES
)
(
   input  logic                                clk,
   input  logic                                sr_rst,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [12:0]                         paddr,
   input  logic [15:0]                         pwdata,
   input  logic [1:0]                          pstrb,
   output logic [15:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output mmu_pkg::slot_wr_t   [NUM_PAGES-1:0] slot_wr,
   input  mmu_pkg::page_desc_t [NUM_PAGES-1:0] slot_desc,
   input  mmu_pkg::xlat_status_t               status,
   output mmu_pkg::mmu_ctrl_t                  ctrl,
   output logic                                umap_en
);
   import mmu_pkg::*;

   localparam int IDX_W = $clog2(NUM_PAGES);

   logic             access;                   // APB access phase
   logic             wr_acc;
   logic             hit_sr0, hit_sr3;
   logic             hit_kbank, hit_ubank;
   logic             hit_par, hit_pdr, hit_any;
   logic [IDX_W-1:0] slot_idx;
   logic [2:0]       sr0_abt;                  // nr, le, ro
   logic             sr0_user;
   logic [2:0]       sr0_page;
   logic             sr0_en;
   logic             sr3_en22, sr3_umap;
   logic [15:0]      sr0_word, sr3_word;

   assign access  = psel & penable;
   assign wr_acc  = access & pwrite;

   // paddr[0] is the byte address, lanes come from pstrb
   assign hit_sr0   = paddr[12:1] == OFS_SR0[12:1];
   assign hit_sr3   = paddr[12:1] == OFS_SR3[12:1];
   assign hit_kbank = paddr[12:6] == OFS_KPDR[12:6];
   assign hit_ubank = paddr[12:6] == OFS_UPDR[12:6];
   assign hit_par   = hit_kbank & (paddr[5:4] == OFS_KPAR[5:4])
                    | hit_ubank & (paddr[5:4] == OFS_UPAR[5:4]);
   assign hit_pdr   = hit_kbank & (paddr[5:4] == OFS_KPDR[5:4])
                    | hit_ubank & (paddr[5:4] == OFS_UPDR[5:4]);
   assign hit_any   = hit_sr0 | hit_sr3 | hit_par | hit_pdr;
   assign slot_idx  = {hit_ubank, paddr[3:1]}; // user bank in upper half

   assign pready  = 1'b1;                      // zero wait states
   assign pslverr = access & ~hit_any;

   always_comb
   begin
      for (int i = 0; i < NUM_PAGES; i++)
      begin
         slot_wr[i].par_en = wr_acc & hit_par & (slot_idx == IDX_W'(i));
         slot_wr[i].pdr_en = wr_acc & hit_pdr & (slot_idx == IDX_W'(i));
         slot_wr[i].strb   = pstrb;
         slot_wr[i].data   = pwdata;
      end
   end

   // SR0: abort bits freeze page and mode until cleared by the CPU
   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         sr0_abt  <= '0;
         sr0_user <= 1'b0;
         sr0_page <= '0;
         sr0_en   <= 1'b0;
      end
      else
      begin
         if (wr_acc & hit_sr0 & pstrb[1])
            sr0_abt <= pwdata[SR0_ABT_LSB +: 3];
         else if (status.valid & (status.nr | status.le | status.ro))
            sr0_abt <= {status.nr, status.le, status.ro};
         if (wr_acc & hit_sr0 & pstrb[0])
            sr0_en <= pwdata[SR0_EN_BIT];
         if (status.valid)                     // already gated by frozen
         begin
            sr0_user <= status.user;
            sr0_page <= status.page;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         sr3_en22 <= 1'b0;
         sr3_umap <= 1'b0;
      end
      else if (wr_acc & hit_sr3 & pstrb[0])
      begin
         sr3_en22 <= pwdata[SR3_EN22_BIT];
         sr3_umap <= pwdata[SR3_UMAP_BIT];
      end
   end

   always_comb
   begin
      sr0_word                    = '0;
      sr0_word[SR0_ABT_LSB +: 3]  = sr0_abt;
      sr0_word[SR0_MODE_LSB +: 2] = {2{sr0_user}};
      sr0_word[SR0_PAGE_LSB +: 3] = sr0_page;
      sr0_word[SR0_EN_BIT]        = sr0_en;
      sr3_word                    = '0;
      sr3_word[SR3_EN22_BIT]      = sr3_en22;
      sr3_word[SR3_UMAP_BIT]      = sr3_umap;
   end

   always_comb
   begin
      if (hit_sr0)
         prdata = sr0_word;
      else if (hit_sr3)
         prdata = sr3_word;
      else if (hit_par)
         prdata = slot_desc[slot_idx].par;
      else if (hit_pdr)
         prdata = slot_desc[slot_idx][15:0] & PDR_READ_MASK;
      else
         prdata = '0;                          // unlisted offset
   end

   assign ctrl.mmu_en   = sr0_en;
   assign ctrl.en_22bit = sr3_en22;
   assign ctrl.frozen   = |sr0_abt;
   assign umap_en       = sr3_umap;

endmodule

// File: verilog/mmu_page_slot.sv
/* MMU page descriptor slot */
`timescale 1ns/10ps

module mmu_page_slot
(
   input  logic                clk,
   input  logic                sr_rst,
   input  mmu_pkg::slot_wr_t   wr,
   input  logic                w_set,
   output mmu_pkg::page_desc_t desc
);
   import mmu_pkg::*;

   logic [PAR_W-1:0] par;                      // base in 64-byte blocks
   logic [6:0]       plf;                      // length in blocks
   logic             ed;                       // expansion direction
   logic [1:0]       acf;                      // access control
   logic             w;                        // dirty flag

   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         par <= '0;
         plf <= '0;
         ed  <= 1'b0;
         acf <= '0;
      end
      else
      begin
         if (wr.par_en & wr.strb[0])
            par[7:0] <= wr.data[7:0];
         if (wr.par_en & wr.strb[1])
            par[15:8] <= wr.data[15:8];
         if (wr.pdr_en & wr.strb[0])
            {ed, acf} <= wr.data[3:1];         // PDR bits 3:1
         if (wr.pdr_en & wr.strb[1])
            plf <= wr.data[14:8];
      end
   end

   // register write wins over a translation setting W
   always_ff @(posedge clk)
   begin
      if (sr_rst)
         w <= 1'b0;
      else if (wr.par_en | wr.pdr_en)
         w <= 1'b0;
      else if (w_set)
         w <= 1'b1;
   end

   always_comb
   begin
      desc     = '0;                           // unimplemented bits read zero
      desc.par = par;
      desc.plf = plf;
      desc.w   = w;
      desc.ed  = ed;
      desc.acf = acf;
   end

endmodule

// File: verilog/mmu_pkg.sv
/* PDP-11 MMU shared types */
package mmu_pkg;

   localparam int VA_W      = 16;              // virtual address
   localparam int PA_W      = 22;              // physical address
   localparam int PAR_W     = 16;              // page base, 64-byte blocks
   localparam int NUM_PAGES = 16;              // 8 kernel + 8 user

   // offsets inside the 8 KB I/O page
   localparam logic [12:0] OFS_SR0  = 13'o17572;
   localparam logic [12:0] OFS_SR3  = 13'o12516;
   localparam logic [12:0] OFS_KPDR = 13'o12300;
   localparam logic [12:0] OFS_KPAR = 13'o12340;
   localparam logic [12:0] OFS_UPDR = 13'o17600;
   localparam logic [12:0] OFS_UPAR = 13'o17640;

   localparam logic [15:0] PDR_READ_MASK = 16'o077516;

   localparam int SR0_EN_BIT   = 0;            // mapping enable
   localparam int SR0_PAGE_LSB = 1;            // page number 3:1
   localparam int SR0_MODE_LSB = 5;            // mode 6:5
   localparam int SR0_ABT_LSB  = 13;           // nr/le/ro 15:13
   localparam int SR3_EN22_BIT = 4;            // 22-bit mapping
   localparam int SR3_UMAP_BIT = 5;            // unibus map

   // low half is laid out as the PDR word
   typedef struct packed {
      logic [PAR_W-1:0] par;                   // page base
      logic             rsv_15;
      logic [6:0]       plf;                   // page length
      logic             rsv_7;
      logic             w;                     // dirty page
      logic [1:0]       rsv_5_4;
      logic             ed;                    // expand downward
      logic [1:0]       acf;                   // [0] resident, [1] write ok
      logic             rsv_0;
   } page_desc_t;

   typedef struct packed {
      logic        par_en;
      logic        pdr_en;
      logic [1:0]  strb;                       // byte lanes
      logic [15:0] data;
   } slot_wr_t;

   typedef struct packed {
      logic [VA_W-1:0] va;
      logic            user;                   // user mode space
      logic            write;
   } xlat_req_t;

   typedef struct packed {
      logic [PA_W-1:0] pa;
      logic            abort_nr;               // non-resident
      logic            abort_le;               // length error
      logic            abort_ro;               // read-only
   } xlat_rsp_t;

   typedef struct packed {
      logic       valid;
      logic       user;
      logic [2:0] page;
      logic       nr;
      logic       le;
      logic       ro;
   } xlat_status_t;

   typedef struct packed {
      logic mmu_en;
      logic en_22bit;
      logic frozen;                            // SR0 holds an abort
   } mmu_ctrl_t;

endpackage
